// ==== verilog/tlb_consts.svh ====
`ifndef TLB_CONSTS_SVH
`define TLB_CONSTS_SVH

// joint TLB geometry
`define TLB_ENTRIES 16
`define TLB_IDX_W   4

`define VPN2_W 19
`define PFN_W  20
`define ASID_W 8

// EntryHi fields
`define EHI_VPN2_HI 31
`define EHI_VPN2_LO 13
`define EHI_ASID_HI 7
`define EHI_ASID_LO 0

// EntryLo fields
`define ELO_PFN_HI 25
`define ELO_PFN_LO 6
`define ELO_C_HI   5
`define ELO_C_LO   3
`define ELO_D      2
`define ELO_V      1
`define ELO_G      0

// cache attribute for uncached pages
`define UNCACHED_C 3'd2

// address bit that picks the odd page of a pair
`define VA_ODD_BIT 12

`endif

// ==== verilog/tlb_pkg.sv ====
`include "tlb_consts.svh"

package tlb_pkg;

    // addresses and CP0 words
    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] cp0_word_t;

    // page numbering
    typedef logic [`VPN2_W-1:0] vpn2_t;
    typedef logic [`PFN_W-1:0]  pfn_t;

    typedef logic [`ASID_W-1:0] asid_t;

    // C field of EntryLo
    typedef logic [2:0] cattr_t;

    // entry addressing
    typedef logic [`TLB_IDX_W-1:0]   tlb_idx_t;
    typedef logic [`TLB_ENTRIES-1:0] entry_onehot_t;

endpackage

// ==== verilog/tlb_cmd_decode.sv ====
`timescale 1ns/100ps
`include "tlb_consts.svh"

module tlb_cmd_decode (
    input  logic                   i_aclk,
    input  logic                   i_rst_n,
    input  logic                   i_tlbwi,
    input  logic                   i_tlbwr,
    input  tlb_pkg::cp0_word_t     i_entryhi,
    input  tlb_pkg::cp0_word_t     i_entrylo0,
    input  tlb_pkg::cp0_word_t     i_entrylo1,
    input  tlb_pkg::cp0_word_t     i_index,
    input  tlb_pkg::cp0_word_t     i_random,
    output tlb_pkg::entry_onehot_t o_wr_en,
    output tlb_pkg::vpn2_t         o_wr_vpn2,
    output tlb_pkg::asid_t         o_wr_asid,
    output logic                   o_wr_g,
    output tlb_pkg::cp0_word_t     o_wr_lo0,
    output tlb_pkg::cp0_word_t     o_wr_lo1
);

    tlb_pkg::tlb_idx_t wr_idx;
    logic              wr_any;

    // keep PFN, C, D and V; G lives once per entry
    function automatic tlb_pkg::cp0_word_t lo_fields(tlb_pkg::cp0_word_t lo);
        tlb_pkg::cp0_word_t f;
        f = '0;
        f[`ELO_PFN_HI:`ELO_V] = lo[`ELO_PFN_HI:`ELO_V];
        return f;
    endfunction

    // write-random takes its slot from Random
    assign wr_idx = i_tlbwi ? i_index[`TLB_IDX_W-1:0] : i_random[`TLB_IDX_W-1:0];
    assign wr_any = i_tlbwi | i_tlbwr;

    always_comb begin
        o_wr_en = '0;
        if (wr_any) begin
            o_wr_en[wr_idx] = 1'b1;
        end
    end

    assign o_wr_vpn2 = i_entryhi[`EHI_VPN2_HI:`EHI_VPN2_LO];
    assign o_wr_asid = i_entryhi[`EHI_ASID_HI:`EHI_ASID_LO];
    // page pair is global only if both halves say so
    assign o_wr_g    = i_entrylo0[`ELO_G] & i_entrylo1[`ELO_G];
    assign o_wr_lo0  = lo_fields(i_entrylo0);
    assign o_wr_lo1  = lo_fields(i_entrylo1);

    a_write_strobes_onehot: assert property (
        @(posedge i_aclk) disable iff (!i_rst_n)
        !(i_tlbwi && i_tlbwr)
    );

    a_wr_en_single: assert property (
        @(posedge i_aclk) disable iff (!i_rst_n)
        $onehot0(o_wr_en)
    );

endmodule

// ==== verilog/tlb_entry.sv ====
`timescale 1ns/100ps
`include "tlb_consts.svh"

module tlb_entry (
    input  logic               i_aclk,
    input  logic               i_rst_n,
    input  logic               i_wr_en,
    input  tlb_pkg::vpn2_t     i_wr_vpn2,
    input  tlb_pkg::asid_t     i_wr_asid,
    input  logic               i_wr_g,
    input  tlb_pkg::cp0_word_t i_wr_lo0,
    input  tlb_pkg::cp0_word_t i_wr_lo1,
    input  tlb_pkg::asid_t     i_cur_asid,
    input  tlb_pkg::vpn2_t     i_inst_vpn2,
    input  tlb_pkg::vpn2_t     i_data_vpn2,
    input  tlb_pkg::vpn2_t     i_probe_vpn2,
    output logic               o_inst_hit,
    output logic               o_data_hit,
    output logic               o_probe_hit,
    output tlb_pkg::vpn2_t     o_vpn2,
    output tlb_pkg::asid_t     o_asid,
    output logic               o_g,
    output tlb_pkg::cp0_word_t o_lo0,
    output tlb_pkg::cp0_word_t o_lo1
);

    tlb_pkg::vpn2_t     vpn2_q;
    tlb_pkg::asid_t     asid_q;
    logic               g_q;
    tlb_pkg::cp0_word_t lo0_q;
    tlb_pkg::cp0_word_t lo1_q;
    logic               asid_ok;

    // the whole mapping clears so that every V bit starts low
    always_ff @(posedge i_aclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            vpn2_q <= '0;
            asid_q <= '0;
            g_q    <= 1'b0;
            lo0_q  <= '0;
            lo1_q  <= '0;
        end else if (i_wr_en) begin
            vpn2_q <= i_wr_vpn2;
            asid_q <= i_wr_asid;
            g_q    <= i_wr_g;
            lo0_q  <= i_wr_lo0;
            lo1_q  <= i_wr_lo1;
        end
    end

    // global pages ignore the ASID
    assign asid_ok = g_q | (asid_q == i_cur_asid);

    // three parallel compares
    assign o_inst_hit  = asid_ok & (vpn2_q == i_inst_vpn2);
    assign o_data_hit  = asid_ok & (vpn2_q == i_data_vpn2);
    assign o_probe_hit = asid_ok & (vpn2_q == i_probe_vpn2);

    assign o_vpn2 = vpn2_q;
    assign o_asid = asid_q;
    assign o_g    = g_q;
    assign o_lo0  = lo0_q;
    assign o_lo1  = lo1_q;

    // decoder must stay quiet while the core is held in reset
    a_no_write_in_reset: assert property (
        @(posedge i_aclk)
        !i_rst_n |-> !i_wr_en
    );

endmodule

// ==== verilog/tlb_lookup_merge.sv ====
`timescale 1ns/100ps
`include "tlb_consts.svh"

module tlb_lookup_merge (
    input  logic                   i_aclk,
    input  logic                   i_rst_n,
    input  logic                   i_inst_req,
    input  tlb_pkg::vaddr_t        i_inst_vaddr,
    input  logic                   i_data_req,
    input  tlb_pkg::vaddr_t        i_data_vaddr,
    input  logic                   i_data_write,
    input  logic                   i_tlbp,
    input  logic                   i_tlbr,
    input  tlb_pkg::cp0_word_t     i_index,
    input  tlb_pkg::entry_onehot_t i_inst_hit,
    input  tlb_pkg::entry_onehot_t i_data_hit,
    input  tlb_pkg::entry_onehot_t i_probe_hit,
    input  tlb_pkg::vpn2_t         i_vpn2 [`TLB_ENTRIES],
    input  tlb_pkg::asid_t         i_asid [`TLB_ENTRIES],
    input  tlb_pkg::entry_onehot_t i_g,
    input  tlb_pkg::cp0_word_t     i_lo0 [`TLB_ENTRIES],
    input  tlb_pkg::cp0_word_t     i_lo1 [`TLB_ENTRIES],
    output logic                   o_inst_valid,
    output tlb_pkg::pfn_t          o_inst_pfn,
    output logic                   o_inst_uncached,
    output logic                   o_inst_refill,
    output logic                   o_inst_invalid,
    output logic                   o_data_valid,
    output tlb_pkg::pfn_t          o_data_pfn,
    output logic                   o_data_uncached,
    output logic                   o_data_refill,
    output logic                   o_data_invalid,
    output logic                   o_data_modify,
    output logic                   o_cp0_valid,
    output tlb_pkg::cp0_word_t     o_index,
    output tlb_pkg::cp0_word_t     o_entryhi,
    output tlb_pkg::cp0_word_t     o_entrylo0,
    output tlb_pkg::cp0_word_t     o_entrylo1
);

    tlb_pkg::tlb_idx_t  inst_idx;
    tlb_pkg::tlb_idx_t  data_idx;
    tlb_pkg::tlb_idx_t  probe_idx;
    tlb_pkg::tlb_idx_t  rd_idx;
    tlb_pkg::cp0_word_t inst_lo;
    tlb_pkg::cp0_word_t data_lo;

    logic               inst_req_q;
    logic               data_req_q;
    logic               probe_q;
    logic               read_q;
    logic               inst_hit_q;
    logic               data_hit_q;
    logic               probe_hit_q;
    logic               data_write_q;
    tlb_pkg::vaddr_t    inst_va_q;
    tlb_pkg::vaddr_t    data_va_q;
    tlb_pkg::cp0_word_t inst_lo_q;
    tlb_pkg::cp0_word_t data_lo_q;
    tlb_pkg::tlb_idx_t  probe_idx_q;
    tlb_pkg::cp0_word_t rd_hi_q;
    tlb_pkg::cp0_word_t rd_lo0_q;
    tlb_pkg::cp0_word_t rd_lo1_q;

    // {pfn, uncached, refill, invalid, modify}
    logic [`PFN_W+3:0]  inst_res;
    logic [`PFN_W+3:0]  data_res;

    // lowest index wins
    function automatic tlb_pkg::tlb_idx_t first_idx(tlb_pkg::entry_onehot_t hits);
        tlb_pkg::tlb_idx_t idx;
        idx = '0;
        for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin
            if (hits[i]) begin
                idx = tlb_pkg::tlb_idx_t'(i);
            end
        end
        return idx;
    endfunction

    function automatic logic [`PFN_W+3:0] xlate(tlb_pkg::vaddr_t va, logic hit,
                                                 tlb_pkg::cp0_word_t lo, logic wr);
        tlb_pkg::cattr_t c;
        logic            refill;
        logic            inval;
        c      = lo[`ELO_C_HI:`ELO_C_LO];
        refill = !hit;
        inval  = hit && !lo[`ELO_V];
        // kseg0/kseg1 are direct mapped, bit 29 picks kseg1
        if (va[31:30] == 2'b10) begin
            return {3'b000, va[28:`VA_ODD_BIT], va[29], 3'b000};
        end
        return {lo[`ELO_PFN_HI:`ELO_PFN_LO], c == `UNCACHED_C, refill, inval,
                wr && hit && lo[`ELO_V] && !lo[`ELO_D]};
    endfunction

    assign inst_idx  = first_idx(i_inst_hit);
    assign data_idx  = first_idx(i_data_hit);
    assign probe_idx = first_idx(i_probe_hit);
    assign rd_idx    = i_index[`TLB_IDX_W-1:0];

    assign inst_lo = i_inst_vaddr[`VA_ODD_BIT] ? i_lo1[inst_idx] : i_lo0[inst_idx];
    assign data_lo = i_data_vaddr[`VA_ODD_BIT] ? i_lo1[data_idx] : i_lo0[data_idx];

    // lookup stage
    always_ff @(posedge i_aclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            inst_req_q <= 1'b0;
            data_req_q <= 1'b0;
            probe_q    <= 1'b0;
            read_q     <= 1'b0;
        end else begin
            inst_req_q <= i_inst_req;
            data_req_q <= i_data_req;
            probe_q    <= i_tlbp;
            read_q     <= i_tlbr;
        end
    end

    always_ff @(posedge i_aclk) begin
        inst_va_q    <= i_inst_vaddr;
        inst_hit_q   <= |i_inst_hit;
        inst_lo_q    <= inst_lo;
        data_va_q    <= i_data_vaddr;
        data_hit_q   <= |i_data_hit;
        data_lo_q    <= data_lo;
        data_write_q <= i_data_write;
        probe_hit_q  <= |i_probe_hit;
        probe_idx_q  <= probe_idx;
        rd_hi_q      <= {i_vpn2[rd_idx], {(`EHI_VPN2_LO - `ASID_W){1'b0}}, i_asid[rd_idx]};
        rd_lo0_q     <= i_lo0[rd_idx];
        rd_lo1_q     <= i_lo1[rd_idx];
        // G goes back into both halves
        rd_lo0_q[`ELO_G] <= i_g[rd_idx];
        rd_lo1_q[`ELO_G] <= i_g[rd_idx];
    end

    assign inst_res = xlate(inst_va_q, inst_hit_q, inst_lo_q, 1'b0);
    assign data_res = xlate(data_va_q, data_hit_q, data_lo_q, data_write_q);

    // result stage, outputs hold until the next request
    always_ff @(posedge i_aclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_inst_valid    <= 1'b0;
            o_inst_pfn      <= '0;
            o_inst_uncached <= 1'b0;
            o_inst_refill   <= 1'b0;
            o_inst_invalid  <= 1'b0;
            o_data_valid    <= 1'b0;
            o_data_pfn      <= '0;
            o_data_uncached <= 1'b0;
            o_data_refill   <= 1'b0;
            o_data_invalid  <= 1'b0;
            o_data_modify   <= 1'b0;
            o_cp0_valid     <= 1'b0;
            o_index         <= '0;
            o_entryhi       <= '0;
            o_entrylo0      <= '0;
            o_entrylo1      <= '0;
        end else begin
            o_inst_valid <= inst_req_q;
            o_data_valid <= data_req_q;
            o_cp0_valid  <= probe_q | read_q;
            if (inst_req_q) begin
                {o_inst_pfn, o_inst_uncached, o_inst_refill, o_inst_invalid} <=
                    inst_res[`PFN_W+3:1];
            end
            if (data_req_q) begin
                {o_data_pfn, o_data_uncached, o_data_refill, o_data_invalid,
                 o_data_modify} <= data_res;
            end
            if (probe_q) begin
                // bit 31 flags a probe miss
                o_index <= probe_hit_q ? tlb_pkg::cp0_word_t'(probe_idx_q) : 32'h8000_0000;
            end
            if (read_q) begin
                o_entryhi  <= rd_hi_q;
                o_entrylo0 <= rd_lo0_q;
                o_entrylo1 <= rd_lo1_q;
            end
        end
    end

    a_inst_exc_exclusive: assert property (
        @(posedge i_aclk) disable iff (!i_rst_n)
        o_inst_valid |-> !(o_inst_refill && o_inst_invalid)
    );

    a_data_exc_exclusive: assert property (
        @(posedge i_aclk) disable iff (!i_rst_n)
        o_data_valid |-> !(o_data_refill && o_data_invalid)
    );

endmodule

// ==== verilog/mmu_top.sv ====
`timescale 1ns/100ps
`include "tlb_consts.svh"

module mmu_top (
    input  logic               i_aclk,
    input  logic               i_rst_n,
    input  logic               i_inst_req,
    input  tlb_pkg::vaddr_t    i_inst_vaddr,
    input  logic               i_data_req,
    input  tlb_pkg::vaddr_t    i_data_vaddr,
    input  logic               i_data_write,
    input  logic               i_tlbp,
    input  logic               i_tlbr,
    input  logic               i_tlbwi,
    input  logic               i_tlbwr,
    input  tlb_pkg::cp0_word_t i_entryhi,
    input  tlb_pkg::cp0_word_t i_entrylo0,
    input  tlb_pkg::cp0_word_t i_entrylo1,
    input  tlb_pkg::cp0_word_t i_index,
    input  tlb_pkg::cp0_word_t i_random,
    output logic               o_inst_valid,
    output tlb_pkg::pfn_t      o_inst_pfn,
    output logic               o_inst_uncached,
    output logic               o_inst_refill,
    output logic               o_inst_invalid,
    output logic               o_data_valid,
    output tlb_pkg::pfn_t      o_data_pfn,
    output logic               o_data_uncached,
    output logic               o_data_refill,
    output logic               o_data_invalid,
    output logic               o_data_modify,
    output logic               o_cp0_valid,
    output tlb_pkg::cp0_word_t o_index,
    output tlb_pkg::cp0_word_t o_entryhi,
    output tlb_pkg::cp0_word_t o_entrylo0,
    output tlb_pkg::cp0_word_t o_entrylo1
);

    // write side
    tlb_pkg::entry_onehot_t wr_en;
    tlb_pkg::vpn2_t         wr_vpn2;
    tlb_pkg::asid_t         wr_asid;
    logic                   wr_g;
    tlb_pkg::cp0_word_t     wr_lo0;
    tlb_pkg::cp0_word_t     wr_lo1;

    // lookup side
    tlb_pkg::entry_onehot_t inst_hit;
    tlb_pkg::entry_onehot_t data_hit;
    tlb_pkg::entry_onehot_t probe_hit;
    tlb_pkg::vpn2_t         ent_vpn2 [`TLB_ENTRIES];
    tlb_pkg::asid_t         ent_asid [`TLB_ENTRIES];
    tlb_pkg::entry_onehot_t ent_g;
    tlb_pkg::cp0_word_t     ent_lo0 [`TLB_ENTRIES];
    tlb_pkg::cp0_word_t     ent_lo1 [`TLB_ENTRIES];

    tlb_cmd_decode tlb_cmd_decode_inst (
        .i_aclk     (i_aclk),
        .i_rst_n    (i_rst_n),
        .i_tlbwi    (i_tlbwi),
        .i_tlbwr    (i_tlbwr),
        .i_entryhi  (i_entryhi),
        .i_entrylo0 (i_entrylo0),
        .i_entrylo1 (i_entrylo1),
        .i_index    (i_index),
        .i_random   (i_random),
        .o_wr_en    (wr_en),
        .o_wr_vpn2  (wr_vpn2),
        .o_wr_asid  (wr_asid),
        .o_wr_g     (wr_g),
        .o_wr_lo0   (wr_lo0),
        .o_wr_lo1   (wr_lo1)
    );

    // current ASID and probe tag both come from EntryHi
    for (genvar i = 0; i < `TLB_ENTRIES; i++) begin : g_entry
        tlb_entry tlb_entry_inst (
            .i_aclk       (i_aclk),
            .i_rst_n      (i_rst_n),
            .i_wr_en      (wr_en[i]),
            .i_wr_vpn2    (wr_vpn2),
            .i_wr_asid    (wr_asid),
            .i_wr_g       (wr_g),
            .i_wr_lo0     (wr_lo0),
            .i_wr_lo1     (wr_lo1),
            .i_cur_asid   (i_entryhi[`EHI_ASID_HI:`EHI_ASID_LO]),
            .i_inst_vpn2  (i_inst_vaddr[`EHI_VPN2_HI:`EHI_VPN2_LO]),
            .i_data_vpn2  (i_data_vaddr[`EHI_VPN2_HI:`EHI_VPN2_LO]),
            .i_probe_vpn2 (i_entryhi[`EHI_VPN2_HI:`EHI_VPN2_LO]),
            .o_inst_hit   (inst_hit[i]),
            .o_data_hit   (data_hit[i]),
            .o_probe_hit  (probe_hit[i]),
            .o_vpn2       (ent_vpn2[i]),
            .o_asid       (ent_asid[i]),
            .o_g          (ent_g[i]),
            .o_lo0        (ent_lo0[i]),
            .o_lo1        (ent_lo1[i])
        );
    end

    tlb_lookup_merge tlb_lookup_merge_inst (
        .i_aclk          (i_aclk),
        .i_rst_n         (i_rst_n),
        .i_inst_req      (i_inst_req),
        .i_inst_vaddr    (i_inst_vaddr),
        .i_data_req      (i_data_req),
        .i_data_vaddr    (i_data_vaddr),
        .i_data_write    (i_data_write),
        .i_tlbp          (i_tlbp),
        .i_tlbr          (i_tlbr),
        .i_index         (i_index),
        .i_inst_hit      (inst_hit),
        .i_data_hit      (data_hit),
        .i_probe_hit     (probe_hit),
        .i_vpn2          (ent_vpn2),
        .i_asid          (ent_asid),
        .i_g             (ent_g),
        .i_lo0           (ent_lo0),
        .i_lo1           (ent_lo1),
        .o_inst_valid    (o_inst_valid),
        .o_inst_pfn      (o_inst_pfn),
        .o_inst_uncached (o_inst_uncached),
        .o_inst_refill   (o_inst_refill),
        .o_inst_invalid  (o_inst_invalid),
        .o_data_valid    (o_data_valid),
        .o_data_pfn      (o_data_pfn),
        .o_data_uncached (o_data_uncached),
        .o_data_refill   (o_data_refill),
        .o_data_invalid  (o_data_invalid),
        .o_data_modify   (o_data_modify),
        .o_cp0_valid     (o_cp0_valid),
        .o_index         (o_index),
        .o_entryhi       (o_entryhi),
        .o_entrylo0      (o_entrylo0),
        .o_entrylo1      (o_entrylo1)
    );

endmodule

// ==== dv/mmu_tb.sv ====
`timescale 1ns/100ps
`include "tlb_consts.svh"

module mmu_tb;

    localparam int CLK_HALF     = 20;
    localparam int RESET_CYCLES = 4;
    localparam int N_KSEG       = 32;
    localparam int N_MAP        = 32;
    localparam int N_UNMAP      = 16;
    localparam int N_PROBE      = 32;
    localparam int N_RWR        = 8;
    localparam int N_ASID       = 32;
    // a lookup, probe or read needs at most 5 cycles, a write 2
    localparam int OP_CYCLES    = 5;
    localparam int TEST_OPS     = N_KSEG + 16 + N_MAP + N_UNMAP + 4 + 8 + N_PROBE + 16
                                  + 2 * N_RWR + N_ASID;
    localparam int CYCLE_LIMIT  = 2 * (RESET_CYCLES + TEST_OPS * OP_CYCLES);

    logic        i_aclk;
    logic        i_rst_n;
    logic        i_inst_req;
    logic [31:0] i_inst_vaddr;
    logic        i_data_req;
    logic [31:0] i_data_vaddr;
    logic        i_data_write;
    logic        i_tlbp;
    logic        i_tlbr;
    logic        i_tlbwi;
    logic        i_tlbwr;
    logic [31:0] i_entryhi;
    logic [31:0] i_entrylo0;
    logic [31:0] i_entrylo1;
    logic [31:0] i_index;
    logic [31:0] i_random;
    logic        o_inst_valid;
    logic [19:0] o_inst_pfn;
    logic        o_inst_uncached;
    logic        o_inst_refill;
    logic        o_inst_invalid;
    logic        o_data_valid;
    logic [19:0] o_data_pfn;
    logic        o_data_uncached;
    logic        o_data_refill;
    logic        o_data_invalid;
    logic        o_data_modify;
    logic        o_cp0_valid;
    logic [31:0] o_index;
    logic [31:0] o_entryhi;
    logic [31:0] o_entrylo0;
    logic [31:0] o_entrylo1;

    // reference TLB
    logic [`VPN2_W-1:0] m_vpn2 [`TLB_ENTRIES];
    logic [`ASID_W-1:0] m_asid [`TLB_ENTRIES];
    logic               m_g    [`TLB_ENTRIES];
    logic [31:0]        m_lo0  [`TLB_ENTRIES];
    logic [31:0]        m_lo1  [`TLB_ENTRIES];
    logic [31:0]        cur_hi;

    logic [31:0] lfsr;
    int          errors;
    int          checks;
    int          failed_tests;
    int          cycles;

    mmu_top mmu_top_inst (
        .i_aclk          (i_aclk),
        .i_rst_n         (i_rst_n),
        .i_inst_req      (i_inst_req),
        .i_inst_vaddr    (i_inst_vaddr),
        .i_data_req      (i_data_req),
        .i_data_vaddr    (i_data_vaddr),
        .i_data_write    (i_data_write),
        .i_tlbp          (i_tlbp),
        .i_tlbr          (i_tlbr),
        .i_tlbwi         (i_tlbwi),
        .i_tlbwr         (i_tlbwr),
        .i_entryhi       (i_entryhi),
        .i_entrylo0      (i_entrylo0),
        .i_entrylo1      (i_entrylo1),
        .i_index         (i_index),
        .i_random        (i_random),
        .o_inst_valid    (o_inst_valid),
        .o_inst_pfn      (o_inst_pfn),
        .o_inst_uncached (o_inst_uncached),
        .o_inst_refill   (o_inst_refill),
        .o_inst_invalid  (o_inst_invalid),
        .o_data_valid    (o_data_valid),
        .o_data_pfn      (o_data_pfn),
        .o_data_uncached (o_data_uncached),
        .o_data_refill   (o_data_refill),
        .o_data_invalid  (o_data_invalid),
        .o_data_modify   (o_data_modify),
        .o_cp0_valid     (o_cp0_valid),
        .o_index         (o_index),
        .o_entryhi       (o_entryhi),
        .o_entrylo0      (o_entrylo0),
        .o_entrylo1      (o_entrylo1)
    );

    initial begin
        i_aclk = 1'b0;
        forever #CLK_HALF i_aclk = ~i_aclk;
    end

    initial begin
        cycles = 0;
        while (cycles <= CYCLE_LIMIT) begin
            @(posedge i_aclk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Some tests failed");
        $finish;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] r);
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            r = {r[30:0], lfsr[0]};
        end
    endtask

    // mapped space only, kseg0/kseg1 pairs move to kseg2
    task automatic rand_vpn2(output logic [`VPN2_W-1:0] v);
        logic [31:0] r;
        rand_bits(`VPN2_W, r);
        v = r[`VPN2_W-1:0];
        if (v[18:17] == 2'b10) begin
            v[17] = 1'b1;
        end
    endtask

    task automatic rand_lo(output logic [31:0] lo);
        logic [31:0] r;
        rand_bits(26, r);
        lo = {6'h00, r[25:0]};
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error at %0t ns: %s: got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    // first matching entry in index order
    function automatic int model_match(logic [`VPN2_W-1:0] vpn2, logic [`ASID_W-1:0] asid);
        int hit;
        hit = -1;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (hit < 0 && m_vpn2[i] == vpn2 && (m_g[i] || m_asid[i] == asid)) begin
                hit = i;
            end
        end
        return hit;
    endfunction

    // {pfn, uncached, refill, invalid, modify}, pfn and uncached zero on an exception
    function automatic logic [23:0] expected_xlate(logic [31:0] va, logic wr);
        int          idx;
        logic [31:0] lo;
        if (va[31:29] == 3'b100) begin
            return {3'b000, va[28:12], 4'b0000};
        end
        if (va[31:29] == 3'b101) begin
            return {3'b000, va[28:12], 4'b1000};
        end
        idx = model_match(va[31:13], cur_hi[7:0]);
        if (idx < 0) begin
            return {20'h0, 4'b0100};
        end
        lo = va[12] ? m_lo1[idx] : m_lo0[idx];
        if (!lo[1]) begin
            return {20'h0, 4'b0010};
        end
        return {lo[25:6], lo[5:3] == 3'd2, 1'b0, 1'b0, wr && !lo[2]};
    endfunction

    function automatic logic [23:0] result_word(logic [19:0] pfn, logic unc, logic refill,
                                                logic inval, logic modify);
        if (refill || inval) begin
            return {20'h0, 1'b0, refill, inval, modify};
        end
        return {pfn, unc, refill, inval, modify};
    endfunction

    task automatic wait_result(input bit cp0, output bit seen);
        int n;
        n = 0;
        seen = 1'b0;
        while (!seen && n < 8) begin
            @(negedge i_aclk);
            seen = cp0 ? o_cp0_valid : o_inst_valid;
            n++;
        end
        if (!seen) begin
            errors++;
            $display("no %s result came back from the DUT within 8 cycles",
                     cp0 ? "CP0" : "translation");
        end
    endtask

    task automatic set_entryhi(input logic [31:0] hi);
        @(posedge i_aclk);
        i_entryhi <= hi;
        cur_hi = hi;
    endtask

    // the unused index register points elsewhere so a wrong source shows up
    task automatic write_tlb(input bit use_random, input logic [3:0] slot,
                             input logic [31:0] hi, input logic [31:0] lo0,
                             input logic [31:0] lo1);
        @(posedge i_aclk);
        i_tlbwi    <= !use_random;
        i_tlbwr    <= use_random;
        i_index    <= {28'h0, use_random ? ~slot : slot};
        i_random   <= {28'h0, use_random ? slot : ~slot};
        i_entryhi  <= hi;
        i_entrylo0 <= lo0;
        i_entrylo1 <= lo1;
        cur_hi = hi;
        @(posedge i_aclk);
        i_tlbwi <= 1'b0;
        i_tlbwr <= 1'b0;
        m_vpn2[slot] = hi[31:13];
        m_asid[slot] = hi[7:0];
        m_g[slot]    = lo0[0] & lo1[0];
        m_lo0[slot]  = lo0;
        m_lo1[slot]  = lo1;
    endtask

    task automatic translate(input logic [31:0] inst_va, input logic [31:0] data_va,
                             input logic wr);
        logic [23:0] exp_i;
        logic [23:0] exp_d;
        bit          seen;
        exp_i = expected_xlate(inst_va, 1'b0);
        exp_d = expected_xlate(data_va, wr);
        @(posedge i_aclk);
        i_inst_req   <= 1'b1;
        i_inst_vaddr <= inst_va;
        i_data_req   <= 1'b1;
        i_data_vaddr <= data_va;
        i_data_write <= wr;
        @(posedge i_aclk);
        i_inst_req <= 1'b0;
        i_data_req <= 1'b0;
        wait_result(1'b0, seen);
        if (seen) begin
            check_value(32'(o_data_valid), 32'd1, "data strobe with inst strobe");
            check_value(32'(result_word(o_inst_pfn, o_inst_uncached, o_inst_refill,
                                        o_inst_invalid, 1'b0)),
                        32'(exp_i), $sformatf("inst va %h", inst_va));
            check_value(32'(result_word(o_data_pfn, o_data_uncached, o_data_refill,
                                        o_data_invalid, o_data_modify)),
                        32'(exp_d), $sformatf("data va %h write %0b", data_va, wr));
        end
    endtask

    task automatic probe_tlb(input logic [31:0] hi);
        int idx;
        bit seen;
        idx = model_match(hi[31:13], hi[7:0]);
        @(posedge i_aclk);
        i_entryhi <= hi;
        i_tlbp    <= 1'b1;
        cur_hi = hi;
        @(posedge i_aclk);
        i_tlbp <= 1'b0;
        wait_result(1'b1, seen);
        if (seen) begin
            check_value(o_index, idx < 0 ? 32'h8000_0000 : 32'(idx),
                        $sformatf("probe entryhi %h", hi));
        end
    endtask

    task automatic read_tlb(input logic [3:0] slot);
        bit seen;
        @(posedge i_aclk);
        i_index <= {28'h0, slot};
        i_tlbr  <= 1'b1;
        @(posedge i_aclk);
        i_tlbr <= 1'b0;
        wait_result(1'b1, seen);
        if (seen) begin
            check_value(o_entryhi, {m_vpn2[slot], 5'h00, m_asid[slot]},
                        $sformatf("read entryhi %0d", slot));
            check_value(o_entrylo0, (m_lo0[slot] & 32'h03ff_fffe) | {31'h0, m_g[slot]},
                        $sformatf("read entrylo0 %0d", slot));
            check_value(o_entrylo1, (m_lo1[slot] & 32'h03ff_fffe) | {31'h0, m_g[slot]},
                        $sformatf("read entrylo1 %0d", slot));
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    initial begin
        logic [31:0]        r;
        logic [31:0]        r2;
        logic [31:0]        va_i;
        logic [31:0]        va_d;
        logic [31:0]        lo0;
        logic [31:0]        lo1;
        logic [`VPN2_W-1:0] vpn2;
        int                 e0;

        lfsr         = 32'h42f7_92a2;
        errors       = 0;
        checks       = 0;
        failed_tests = 0;
        cur_hi       = '0;
        i_rst_n      = 1'b0;
        i_inst_req   = 1'b0;
        i_inst_vaddr = '0;
        i_data_req   = 1'b0;
        i_data_vaddr = '0;
        i_data_write = 1'b0;
        i_tlbp       = 1'b0;
        i_tlbr       = 1'b0;
        i_tlbwi      = 1'b0;
        i_tlbwr      = 1'b0;
        i_entryhi    = '0;
        i_entrylo0   = '0;
        i_entrylo1   = '0;
        i_index      = '0;
        i_random     = '0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            m_vpn2[i] = '0;
            m_asid[i] = '0;
            m_g[i]    = 1'b0;
            m_lo0[i]  = '0;
            m_lo1[i]  = '0;
        end
        repeat (RESET_CYCLES) @(posedge i_aclk);
        i_rst_n <= 1'b1;
        @(negedge i_aclk);

        e0 = errors;
        check_value(32'(o_inst_valid | o_data_valid | o_cp0_valid), 32'd0,
                    "strobes after reset");
        for (int k = 0; k < N_KSEG; k++) begin
            rand_bits(30, r);
            rand_bits(30, r2);
            va_i = {2'b10, r[29:0]};
            va_d = {2'b10, r2[29:0]};
            rand_bits(1, r);
            translate(va_i, va_d, r[0]);
        end
        end_test("kseg0 and kseg1", e0);

        e0 = errors;
        for (int k = 0; k < `TLB_ENTRIES; k++) begin
            rand_vpn2(vpn2);
            rand_lo(lo0);
            rand_lo(lo1);
            lo0[1] = 1'b1;
            lo1[1] = 1'b1;
            write_tlb(1'b0, 4'(k), {vpn2, 5'h00, 8'h35}, lo0, lo1);
        end
        for (int k = 0; k < N_MAP; k++) begin
            rand_bits(17, r);
            rand_bits(17, r2);
            va_i = {m_vpn2[r[16:13]], r[12:0]};
            va_d = {m_vpn2[r2[16:13]], r2[12:0]};
            rand_bits(1, r);
            translate(va_i, va_d, r[0]);
        end
        for (int k = 0; k < N_UNMAP; k++) begin
            rand_vpn2(vpn2);
            rand_bits(13, r);
            translate({vpn2, r[12:0]}, {vpn2, ~r[12:0]}, 1'b0);
        end
        end_test("mapped lookups and refill", e0);

        // even slots invalid, odd slots valid but clean
        e0 = errors;
        for (int k = 0; k < 4; k++) begin
            rand_vpn2(vpn2);
            rand_lo(lo0);
            rand_lo(lo1);
            lo0[2:1] = {1'b0, k[0]};
            lo1[2:1] = {1'b0, k[0]};
            write_tlb(1'b0, 4'(k), {vpn2, 5'h00, 8'h35}, lo0, lo1);
        end
        for (int k = 0; k < 4; k++) begin
            rand_bits(13, r);
            va_d = {m_vpn2[k], r[12:0]};
            translate(va_d, va_d, 1'b1);
            translate(va_d, va_d, 1'b0);
        end
        end_test("invalid and modify", e0);

        e0 = errors;
        for (int k = 0; k < N_PROBE; k++) begin
            rand_bits(2, r);
            if (r[1]) begin
                rand_bits(4, r2);
                probe_tlb({m_vpn2[r2[3:0]], 5'h00, r[0] ? 8'h35 : 8'h7a});
            end else begin
                rand_vpn2(vpn2);
                probe_tlb({vpn2, 5'h00, 8'h35});
            end
        end
        end_test("probe", e0);

        e0 = errors;
        for (int k = 0; k < `TLB_ENTRIES; k++) begin
            read_tlb(4'(k));
        end
        end_test("read", e0);

        e0 = errors;
        for (int k = 0; k < N_RWR; k++) begin
            rand_vpn2(vpn2);
            rand_lo(lo0);
            rand_lo(lo1);
            lo0[1] = 1'b1;
            lo1[1] = 1'b1;
            rand_bits(5, r);
            write_tlb(1'b1, r[3:0], {vpn2, 5'h00, r[4] ? 8'h7a : 8'h35}, lo0, lo1);
            read_tlb(r[3:0]);
        end
        set_entryhi({`VPN2_W'(0), 5'h00, 8'h7a});
        for (int k = 0; k < N_ASID; k++) begin
            rand_bits(17, r);
            rand_bits(17, r2);
            va_i = {m_vpn2[r[16:13]], r[12:0]};
            va_d = {m_vpn2[r2[16:13]], r2[12:0]};
            translate(va_i, va_d, 1'b0);
        end
        end_test("write-random and ASID", e0);

        $display("tests: 6, tests with errors: %0d, checks: %0d, errors: %0d",
                 failed_tests, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== mmu.f ====
+incdir+verilog
verilog/tlb_pkg.sv
verilog/tlb_cmd_decode.sv
verilog/tlb_entry.sv
verilog/tlb_lookup_merge.sv
verilog/mmu_top.sv
dv/mmu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the MMU testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module mmu_tb -f mmu.f -o mmu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/mmu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed" "$LOG"; then
    exit 0
fi
echo "simulation did not pass, see $LOG"
exit 1
